// ==== sources.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/rv_core.sv
tb/rv_core_tb.sv

// ==== include/tb_programs.svh ====
// included inside rv_core_tb; hand-assembled rv32i words, each program at most 16 words
`ifndef tb_programs_svh
`define tb_programs_svh

localparam int prog_count = 7;
localparam int rom_words  = 74;   // all programs back to back
localparam int check_rows = 43;

// one expected register value per row
typedef struct packed {
  logic [2:0]  prog;
  logic [4:0]  idx;
  logic [31:0] value;
} reg_check_t;

// placement of each program in prog_rom, and whether it ends in a halt
int   prog_start [prog_count] = '{0, 16, 28, 42, 56, 65, 70};
int   prog_len   [prog_count] = '{16, 12, 14, 14, 9, 5, 4};
logic prog_halts [prog_count] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

logic [31:0] prog_rom [rom_words] = '{
  // program 0, alu ops with operands forwarded back to back
  32'h00C00093, 32'hFFB00113,  // addi x1,x0,12     addi x2,x0,-5
  32'h002081B3, 32'h40208233,  // add x3,x1,x2      sub x4,x1,x2
  32'h0020F2B3, 32'h0020E333,  // and x5,x1,x2      or x6,x1,x2
  32'h0020C3B3, 32'h00112433,  // xor x7,x1,x2      slt x8,x2,x1
  32'h001114B3, 32'h00115533,  // sll x9,x2,x1      srl x10,x2,x1
  32'h401155B3, 32'h0060F613,  // sra x11,x2,x1     andi x12,x1,6
  32'hFFF0C693, 32'hFFC12713,  // xori x13,x1,-1    slti x14,x2,-4
  32'h00A00893, 32'h00000073,  // addi x17,x0,10    ecall
  // program 1, forwarding and load-use
  32'h00500093, 32'h00308113,  // addi x1,x0,5      addi x2,x1,3
  32'h00100193, 32'h00208233,  // addi x3,x0,1      add x4,x1,x2 (x2 two back)
  32'h00402423, 32'h00802283,  // sw x4,8(x0)       lw x5,8(x0)
  32'h00128333, 32'h00612623,  // add x6,x5,x1      sw x6,12(x2)
  32'h01402383, 32'h40538433,  // lw x7,20(x0)      sub x8,x7,x5
  32'h00A00893, 32'h00000073,  // addi x17,x0,10    ecall
  // program 2, beq and bne; x5 counts targets, x6 fall-throughs
  32'h00300093, 32'hFFE00113,  // addi x1,x0,3      addi x2,x0,-2
  32'h00108463, 32'h00100513,  // beq x1,x1,+8 T    addi x10,x0,1 (shadow)
  32'h00128293, 32'h00208463,  // addi x5,x5,1      beq x1,x2,+8 NT
  32'h00130313, 32'h00209463,  // addi x6,x6,1      bne x1,x2,+8 T
  32'h00100593, 32'h00128293,  // addi x11,x0,1     addi x5,x5,1
  32'h00211463, 32'h00130313,  // bne x2,x2,+8 NT   addi x6,x6,1
  32'h00A00893, 32'h00000073,  // addi x17,x0,10    ecall
  // program 3, blt and bge, signed compares
  32'h00300093, 32'hFFE00113,  // addi x1,x0,3      addi x2,x0,-2
  32'h00114463, 32'h00100513,  // blt x2,x1,+8 T    addi x10,x0,1 (shadow)
  32'h00128293, 32'h0020C463,  // addi x5,x5,1      blt x1,x2,+8 NT
  32'h00130313, 32'h0020D463,  // addi x6,x6,1      bge x1,x2,+8 T
  32'h00100593, 32'h00128293,  // addi x11,x0,1     addi x5,x5,1
  32'h00115463, 32'h00130313,  // bge x2,x1,+8 NT   addi x6,x6,1
  32'h00A00893, 32'h00000073,  // addi x17,x0,10    ecall
  // program 4, jal then jalr on a forwarded odd base
  32'h00C000EF, 32'h00100513,  // jal x1,+12        addi x10,x0,1 (shadow)
  32'h00100593, 32'h01108193,  // addi x11,x0,1     addi x3,x1,17
  32'h00418267, 32'h00100613,  // jalr x4,4(x3)     addi x12,x0,1 (shadow)
  32'h00120293, 32'h00A00893,  // addi x5,x4,1      addi x17,x0,10
  32'h00000073,                // ecall
  // program 5, ecall with x17 = 3 is a nop, then x17 = 10 halts
  32'h00300893, 32'h00000073,  // addi x17,x0,3     ecall
  32'h06400093, 32'h00788893,  // addi x1,x0,100    addi x17,x17,7
  32'h00000073,                // ecall
  // program 6, ecall with x17 = 9 never halts, jal x0 spins in place
  32'h00900893, 32'h00000073,  // addi x17,x0,9     ecall
  32'h00500093, 32'h0000006F   // addi x1,x0,5      jal x0,0 (spin)
};

// registers not listed here must read zero after the halt
reg_check_t reg_checks [check_rows] = '{
  {3'd0, 5'd1, 32'h0000000C}, {3'd0, 5'd2, 32'hFFFFFFFB}, {3'd0, 5'd3, 32'h00000007},
  {3'd0, 5'd4, 32'h00000011}, {3'd0, 5'd5, 32'h00000008}, {3'd0, 5'd6, 32'hFFFFFFFF},
  {3'd0, 5'd7, 32'hFFFFFFF7}, {3'd0, 5'd8, 32'h00000001}, {3'd0, 5'd9, 32'hFFFFB000},
  {3'd0, 5'd10, 32'h000FFFFF}, {3'd0, 5'd11, 32'hFFFFFFFF}, {3'd0, 5'd12, 32'h00000004},
  {3'd0, 5'd13, 32'hFFFFFFF3}, {3'd0, 5'd14, 32'h00000001}, {3'd0, 5'd17, 32'h0000000A},
  {3'd1, 5'd1, 32'h00000005}, {3'd1, 5'd2, 32'h00000008}, {3'd1, 5'd3, 32'h00000001},
  {3'd1, 5'd4, 32'h0000000D}, {3'd1, 5'd5, 32'h0000000D}, {3'd1, 5'd6, 32'h00000012},
  {3'd1, 5'd7, 32'h00000012}, {3'd1, 5'd8, 32'h00000005}, {3'd1, 5'd17, 32'h0000000A},
  {3'd2, 5'd1, 32'h00000003}, {3'd2, 5'd2, 32'hFFFFFFFE}, {3'd2, 5'd5, 32'h00000002},
  {3'd2, 5'd6, 32'h00000002}, {3'd2, 5'd17, 32'h0000000A},
  {3'd3, 5'd1, 32'h00000003}, {3'd3, 5'd2, 32'hFFFFFFFE}, {3'd3, 5'd5, 32'h00000002},
  {3'd3, 5'd6, 32'h00000002}, {3'd3, 5'd17, 32'h0000000A},
  {3'd4, 5'd1, 32'h00000004}, {3'd4, 5'd3, 32'h00000015}, {3'd4, 5'd4, 32'h00000014},
  {3'd4, 5'd5, 32'h00000015}, {3'd4, 5'd17, 32'h0000000A},
  {3'd5, 5'd1, 32'h00000064}, {3'd5, 5'd17, 32'h0000000A},
  {3'd6, 5'd1, 32'h00000005}, {3'd6, 5'd17, 32'h00000009}
};

`endif

// ==== tb/rv_core_tb.sv ====
// imem model holds 64 words; data ram keeps its contents across programs, so loads read own stores
`timescale 1ns/1ps

module rv_core_tb;

  localparam int imem_words   = 64;
  localparam int imem_idx_w   = $clog2(imem_words);
  localparam int halt_limit   = 500;  // cycles per program
  localparam int reset_cycles = 16;

  logic                    clk;
  logic                    reset;
  logic [rv_pkg::xlen-1:0] imem_addr;
  rv_pkg::inst_t           imem_data;
  logic                    is_halted;
  logic [rv_pkg::xlen-1:0] print_reg [rv_pkg::reg_count];

  logic [31:0] imem [imem_words];
  int          value_errors;
  int          timeouts;
  int          checks;

  `include "tb_programs.svh"

  rv_core i_dut (
    .clk, .reset, .imem_addr, .imem_data, .is_halted, .print_reg
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // word read from the pc the edge just set
  always @(posedge clk) begin
    #1 imem_data = imem[imem_addr[2 +: imem_idx_w]];
  end

  task automatic check_reg(input string name, input logic [rv_pkg::xlen-1:0] got,
                           input logic [rv_pkg::xlen-1:0] want);
    checks++;
    if (got !== want) begin
      value_errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      value_errors++;
      $display("Fail %0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // addi rd, x0, imm with random rd and imm
  function automatic logic [31:0] filler_addi();
    logic [31:0] r;
    r = $urandom;
    return {r[31:20], 5'd0, 3'b000, r[11:7], rv_pkg::op_itype};
  endfunction

  task automatic load_program(input int p);
    for (int i = 0; i < imem_words; i++) begin
      if (i < prog_len[p])
        imem[i] = prog_rom[prog_start[p] + i];
      else
        imem[i] = filler_addi();  // never retires behind a halt
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  // polls on the falling edge, away from the register updates
  task automatic wait_for_halt(output logic halted);
    int n;
    halted = 1'b0;
    n = 0;
    while (!halted && n < halt_limit) begin
      @(negedge clk);
      halted = is_halted;
      n++;
    end
  endtask

  task automatic run_program(input int p);
    logic [rv_pkg::xlen-1:0] want [rv_pkg::reg_count];
    logic                    halted;
    load_program(p);
    apply_reset();
    wait_for_halt(halted);
    if (prog_halts[p] && !halted) begin
      timeouts++;
      $display("program %0d did not halt within %0d cycles", p, halt_limit);
    end else begin
      check_flag($sformatf("is_halted program %0d", p), halted, prog_halts[p]);
    end
    for (int r = 0; r < rv_pkg::reg_count; r++) begin
      want[r] = '0;  // untouched registers stay at reset value
    end
    for (int k = 0; k < check_rows; k++) begin
      if (reg_checks[k].prog == p)
        want[reg_checks[k].idx] = reg_checks[k].value;
    end
    for (int r = 0; r < rv_pkg::reg_count; r++) begin
      check_reg($sformatf("print_reg[%0d] program %0d", r, p), print_reg[r], want[r]);
    end
  endtask

  initial begin
    int seed;
    reset        = 1'b1;
    imem_data    = '0;
    value_errors = 0;
    timeouts     = 0;
    checks       = 0;
    seed         = 32'h1ce2_daeb;
    seed         = $urandom(seed);  // seeds the generator once
    for (int p = 0; p < prog_count; p++) begin
      run_program(p);
    end
    $display("errors: %0d wrong values, %0d timeouts, %0d checks run",
             value_errors, timeouts, checks);
    if (value_errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/rv_core.sv ====
// five-stage rv32i core; instruction memory lives outside and must answer combinationally
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    reset,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  rv_pkg::inst_t           imem_data,
  output logic                    is_halted,
  output logic [rv_pkg::xlen-1:0] print_reg [rv_pkg::reg_count]
);

  // IF/ID
  rv_pkg::inst_t           id_inst;
  logic [rv_pkg::xlen-1:0] id_pc;
  logic                    id_valid;

  // hazard and redirect
  logic                    stall;
  logic                    redirect;
  logic [rv_pkg::xlen-1:0] redirect_pc;

  // ID/EX
  logic                          ex_valid;
  logic [rv_pkg::xlen-1:0]       ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
  logic [rv_pkg::reg_addr_w-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [rv_pkg::alu_op_w-1:0]   ex_alu_op;
  logic                          ex_alu_src, ex_reg_write, ex_mem_read, ex_mem_write;
  logic                          ex_link, ex_is_branch, ex_is_jal, ex_is_jalr, ex_is_ecall;
  logic [2:0]                    ex_funct3;

  // EX/MEM
  logic [rv_pkg::xlen-1:0]       mem_alu, mem_store_data, mem_pc;
  logic [rv_pkg::reg_addr_w-1:0] mem_rd;
  logic mem_reg_write, mem_read_en, mem_write_en, mem_link, mem_halt;

  // write-back
  logic                          wb_we;
  logic [rv_pkg::reg_addr_w-1:0] wb_rd;
  logic [rv_pkg::xlen-1:0]       wb_data;

  fetch_stage i_fetch (
    .clk, .reset, .stall, .redirect, .redirect_pc, .imem_data,
    .imem_addr, .id_inst, .id_pc, .id_valid
  );

  decode_stage i_decode (
    .clk, .reset, .id_inst, .id_pc, .id_valid, .redirect, .wb_we, .wb_rd, .wb_data,
    .stall, .print_reg, .ex_valid, .ex_pc, .ex_rs1, .ex_rs2, .ex_rd,
    .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_alu_op, .ex_alu_src, .ex_reg_write,
    .ex_mem_read, .ex_mem_write, .ex_link, .ex_is_branch, .ex_is_jal, .ex_is_jalr,
    .ex_is_ecall, .ex_funct3
  );

  execute_stage i_execute (
    .clk, .reset, .ex_valid, .ex_pc, .ex_rs1, .ex_rs2, .ex_rd,
    .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_alu_op, .ex_alu_src, .ex_reg_write,
    .ex_mem_read, .ex_mem_write, .ex_link, .ex_is_branch, .ex_is_jal, .ex_is_jalr,
    .ex_is_ecall, .ex_funct3, .wb_we, .wb_rd, .wb_data,
    .redirect, .redirect_pc, .mem_alu, .mem_store_data, .mem_rd, .mem_reg_write,
    .mem_read_en, .mem_write_en, .mem_link, .mem_pc, .mem_halt
  );

  memory_stage i_memory (
    .clk, .reset, .mem_alu, .mem_store_data, .mem_rd, .mem_reg_write,
    .mem_read_en, .mem_write_en, .mem_link, .mem_pc, .mem_halt,
    .wb_we, .wb_rd, .wb_data, .is_halted
  );

endmodule

// ==== verilog/memory_stage.sv ====
// word-only data ram, address wraps at dmem_words; is_halted is cleared only by reset
`timescale 1ns/1ps

module memory_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::xlen-1:0]       mem_alu,
  input  logic [rv_pkg::xlen-1:0]       mem_store_data,
  input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  input  logic                          mem_reg_write,
  input  logic                          mem_read_en,
  input  logic                          mem_write_en,
  input  logic                          mem_link,
  input  logic [rv_pkg::xlen-1:0]       mem_pc,
  input  logic                          mem_halt,
  output logic                          wb_we,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          is_halted
);

  logic [rv_pkg::xlen-1:0]       ram [rv_pkg::dmem_words];
  logic [rv_pkg::dmem_idx_w-1:0] idx;
  logic [rv_pkg::xlen-1:0]       result;

  assign idx = mem_alu[rv_pkg::byte_off_w +: rv_pkg::dmem_idx_w];  // drop byte offset

  always_ff @(posedge clk) begin
    if (mem_write_en)
      ram[idx] <= mem_store_data;
  end

  // load data, link value or alu result
  always_comb begin
    if (mem_read_en)
      result = ram[idx];  // async read
    else if (mem_link)
      result = mem_pc + rv_pkg::pc_step;
    else
      result = mem_alu;
  end

  // MEM/WB and sticky halt
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_we     <= 1'b0;
      is_halted <= 1'b0;
    end else begin
      wb_we     <= mem_reg_write;
      is_halted <= is_halted || mem_halt;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= result;
  end

endmodule

// ==== verilog/execute_stage.sv ====
// branches and jumps resolve here; a halting ecall redirects to itself so nothing younger retires
`timescale 1ns/1ps

module execute_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          ex_valid,
  input  logic [rv_pkg::xlen-1:0]       ex_pc,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  input  logic [rv_pkg::xlen-1:0]       ex_rs1_data,
  input  logic [rv_pkg::xlen-1:0]       ex_rs2_data,
  input  logic [rv_pkg::xlen-1:0]       ex_imm,
  input  logic [rv_pkg::alu_op_w-1:0]   ex_alu_op,
  input  logic                          ex_alu_src,
  input  logic                          ex_reg_write,
  input  logic                          ex_mem_read,
  input  logic                          ex_mem_write,
  input  logic                          ex_link,
  input  logic                          ex_is_branch,
  input  logic                          ex_is_jal,
  input  logic                          ex_is_jalr,
  input  logic                          ex_is_ecall,
  input  logic [2:0]                    ex_funct3,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          redirect,
  output logic [rv_pkg::xlen-1:0]       redirect_pc,
  output logic [rv_pkg::xlen-1:0]       mem_alu,
  output logic [rv_pkg::xlen-1:0]       mem_store_data,
  output logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  output logic                          mem_reg_write,
  output logic                          mem_read_en,
  output logic                          mem_write_en,
  output logic                          mem_link,
  output logic [rv_pkg::xlen-1:0]       mem_pc,
  output logic                          mem_halt
);

  logic [rv_pkg::xlen-1:0] mem_fwd;        // value EX/MEM will write back
  logic [rv_pkg::xlen-1:0] op_a, op_b;     // forwarded register values
  logic [rv_pkg::xlen-1:0] alu_b, alu_y, target;
  logic cond, taken, halt;

  // a link in EX/MEM writes pc+4, not its alu value
  assign mem_fwd = mem_link ? mem_pc + rv_pkg::pc_step : mem_alu;

  // EX/MEM first, then write-back, x0 never
  always_comb begin
    if (mem_reg_write && mem_rd != '0 && mem_rd == ex_rs1)
      op_a = mem_fwd;
    else if (wb_we && wb_rd != '0 && wb_rd == ex_rs1)
      op_a = wb_data;
    else
      op_a = ex_rs1_data;
    if (mem_reg_write && mem_rd != '0 && mem_rd == ex_rs2)
      op_b = mem_fwd;
    else if (wb_we && wb_rd != '0 && wb_rd == ex_rs2)
      op_b = wb_data;
    else
      op_b = ex_rs2_data;
  end

  assign alu_b = ex_alu_src ? ex_imm : op_b;

  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_sub: alu_y = op_a - alu_b;
      rv_pkg::alu_and: alu_y = op_a & alu_b;
      rv_pkg::alu_or:  alu_y = op_a | alu_b;
      rv_pkg::alu_xor: alu_y = op_a ^ alu_b;
      rv_pkg::alu_slt: alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
      rv_pkg::alu_sll: alu_y = op_a << alu_b[4:0];
      rv_pkg::alu_srl: alu_y = op_a >> alu_b[4:0];
      rv_pkg::alu_sra: alu_y = $unsigned($signed(op_a) >>> alu_b[4:0]);
      default:         alu_y = op_a + alu_b;
    endcase
  end

  // branch compare on raw register operands
  always_comb begin
    case (ex_funct3)
      rv_pkg::f3_beq: cond = op_a == op_b;
      rv_pkg::f3_bne: cond = op_a != op_b;
      rv_pkg::f3_blt: cond = $signed(op_a) < $signed(op_b);
      rv_pkg::f3_bge: cond = $signed(op_a) >= $signed(op_b);
      default:        cond = 1'b0;
    endcase
  end

  assign taken  = ex_valid && (ex_is_jal || ex_is_jalr || (ex_is_branch && cond));
  assign halt   = ex_valid && ex_is_ecall && op_a == rv_pkg::halt_code;
  assign target = ex_is_jalr ? {alu_y[rv_pkg::xlen-1:1], 1'b0} : ex_pc + ex_imm;

  assign redirect    = taken || halt;
  assign redirect_pc = halt ? ex_pc : target;  // spin on the ecall

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write <= 1'b0;
      mem_read_en   <= 1'b0;
      mem_write_en  <= 1'b0;
      mem_link      <= 1'b0;
      mem_halt      <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_read_en   <= ex_mem_read;
      mem_write_en  <= ex_mem_write;
      mem_link      <= ex_link;
      mem_halt      <= halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    mem_alu        <= alu_y;
    mem_store_data <= op_b;
    mem_rd         <= ex_rd;
    mem_pc         <= ex_pc;
  end

endmodule

// ==== verilog/decode_stage.sv ====
// write-first register file; one bubble per load-use; ecall reads x17 through rs1
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  rv_pkg::inst_t                 id_inst,
  input  logic [rv_pkg::xlen-1:0]       id_pc,
  input  logic                          id_valid,
  input  logic                          redirect,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          stall,
  output logic [rv_pkg::xlen-1:0]       print_reg [rv_pkg::reg_count],
  output logic                          ex_valid,
  output logic [rv_pkg::xlen-1:0]       ex_pc,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  output logic [rv_pkg::xlen-1:0]       ex_rs1_data,
  output logic [rv_pkg::xlen-1:0]       ex_rs2_data,
  output logic [rv_pkg::xlen-1:0]       ex_imm,
  output logic [rv_pkg::alu_op_w-1:0]   ex_alu_op,
  output logic                          ex_alu_src,
  output logic                          ex_reg_write,
  output logic                          ex_mem_read,
  output logic                          ex_mem_write,
  output logic                          ex_link,
  output logic                          ex_is_branch,
  output logic                          ex_is_jal,
  output logic                          ex_is_jalr,
  output logic                          ex_is_ecall,
  output logic [2:0]                    ex_funct3
);

  logic [rv_pkg::xlen-1:0]       regs [rv_pkg::reg_count];
  logic [rv_pkg::xlen-1:0]       imm_i, imm_s, imm_b, imm_j, imm;
  logic [rv_pkg::xlen-1:0]       rs1_data, rs2_data;
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::alu_op_w-1:0]   f3_alu, alu_op;
  logic alu_src, reg_write, mem_read, mem_write, link;
  logic is_branch, is_jal, is_jalr, is_ecall;
  logic use_rs1, use_rs2, alt, bubble;

  // immediates, sign bit is always inst[31]
  assign imm_i = {{20{id_inst.r.funct7[6]}}, id_inst.r.funct7, id_inst.r.rs2};
  assign imm_s = {{20{id_inst.s.imm_hi[6]}}, id_inst.s.imm_hi, id_inst.s.imm_lo};
  assign imm_b = {{20{id_inst.s.imm_hi[6]}}, id_inst.s.imm_lo[0], id_inst.s.imm_hi[5:0],
                  id_inst.s.imm_lo[4:1], 1'b0};
  assign imm_j = {{12{id_inst.r.funct7[6]}}, id_inst.r.rs1, id_inst.r.funct3,
                  id_inst.r.rs2[0], id_inst.r.funct7[5:0], id_inst.r.rs2[4:1], 1'b0};

  // funct7[5] picks sub/sra, r-type only
  assign alt = id_inst.r.funct7[5] && (id_inst.r.opcode == rv_pkg::op_rtype);

  always_comb begin
    case (id_inst.r.funct3)
      rv_pkg::f3_add: f3_alu = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll: f3_alu = rv_pkg::alu_sll;
      rv_pkg::f3_slt: f3_alu = rv_pkg::alu_slt;
      rv_pkg::f3_xor: f3_alu = rv_pkg::alu_xor;
      rv_pkg::f3_srl: f3_alu = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:  f3_alu = rv_pkg::alu_or;
      default:        f3_alu = rv_pkg::alu_and;
    endcase
  end

  // main control decode
  always_comb begin
    imm       = imm_i;
    alu_op    = rv_pkg::alu_add;  // address and jalr target adds
    alu_src   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    link      = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ecall  = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (id_inst.r.opcode)
      rv_pkg::op_rtype: begin
        alu_op    = f3_alu;
        reg_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      rv_pkg::op_itype: begin
        alu_op    = f3_alu;
        alu_src   = 1'b1;
        reg_write = 1'b1;
        use_rs1   = 1'b1;
      end
      rv_pkg::op_load: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
        use_rs1   = 1'b1;
      end
      rv_pkg::op_store: begin
        imm       = imm_s;
        alu_src   = 1'b1;
        mem_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;  // store data
      end
      rv_pkg::op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      rv_pkg::op_jal: begin
        imm       = imm_j;
        reg_write = 1'b1;
        link      = 1'b1;
        is_jal    = 1'b1;
      end
      rv_pkg::op_jalr: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        link      = 1'b1;
        is_jalr   = 1'b1;
        use_rs1   = 1'b1;
      end
      rv_pkg::op_system: begin
        is_ecall  = 1'b1;
        use_rs1   = 1'b1;  // x17 via normal forwarding
      end
      default: ;  // unknown opcode acts as a nop
    endcase
  end

  assign rs1 = is_ecall ? rv_pkg::ecall_arg_reg : id_inst.r.rs1;

  // register file, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // same-cycle write passes through to the read
  assign rs1_data = (wb_we && wb_rd != '0 && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (wb_we && wb_rd != '0 && wb_rd == id_inst.r.rs2) ? wb_data
                                                                    : regs[id_inst.r.rs2];
  assign print_reg = regs;

  // load in ID/EX feeding this instruction
  assign stall = id_valid && ex_mem_read && ex_rd != '0 &&
                 ((use_rs1 && ex_rd == rs1) || (use_rs2 && ex_rd == id_inst.r.rs2));
  assign bubble = redirect || !id_valid || stall;

  // ID/EX control bits
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_link      <= 1'b0;
      ex_is_branch <= 1'b0;
      ex_is_jal    <= 1'b0;
      ex_is_jalr   <= 1'b0;
      ex_is_ecall  <= 1'b0;
    end else begin
      ex_valid     <= !bubble;
      ex_reg_write <= reg_write && !bubble;
      ex_mem_read  <= mem_read && !bubble;
      ex_mem_write <= mem_write && !bubble;
      ex_link      <= link && !bubble;
      ex_is_branch <= is_branch && !bubble;
      ex_is_jal    <= is_jal && !bubble;
      ex_is_jalr   <= is_jalr && !bubble;
      ex_is_ecall  <= is_ecall && !bubble;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    ex_pc       <= id_pc;
    ex_rs1      <= rs1;
    ex_rs2      <= id_inst.r.rs2;
    ex_rd       <= id_inst.r.rd;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_alu_op   <= alu_op;
    ex_alu_src  <= alu_src;
    ex_funct3   <= id_inst.r.funct3;
  end

endmodule

// ==== verilog/fetch_stage.sv ====
// predicts not-taken; redirect takes priority over stall; imem must answer in the same cycle
`timescale 1ns/1ps

module fetch_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_pc,
  input  rv_pkg::inst_t           imem_data,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  output rv_pkg::inst_t           id_inst,
  output logic [rv_pkg::xlen-1:0] id_pc,
  output logic                    id_valid
);

  logic [rv_pkg::xlen-1:0] pc;

  assign imem_addr = pc;  // fetch port straight off the pc

  // pc and IF/ID valid
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= rv_pkg::reset_pc;
      id_valid <= 1'b0;
    end else if (redirect) begin
      pc       <= redirect_pc;
      id_valid <= 1'b0;       // word in flight is on the wrong path
    end else if (!stall) begin
      pc       <= pc + rv_pkg::pc_step;
      id_valid <= 1'b1;
    end
  end

  // IF/ID payload, held during a stall
  always_ff @(posedge clk) begin
    if (!stall || redirect) begin
      id_inst <= imem_data;
      id_pc   <= pc;
    end
  end

endmodule

// ==== verilog/rv_pkg.sv ====
// rv32i subset only: no csr, byte/half memory ops or u-type; data ram depth must be a power of two
package rv_pkg;

  // widths and sizes
  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int reg_count   = 32;
  localparam int alu_op_w    = 4;
  localparam int byte_off_w  = 2;   // word aligned data accesses
  localparam int dmem_words  = 64;
  localparam int dmem_idx_w  = $clog2(dmem_words);

  localparam logic [xlen-1:0] pc_step  = 32'd4;
  localparam logic [xlen-1:0] reset_pc = 32'd0;

  // major opcodes
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for alu ops
  localparam logic [2:0] f3_add = 3'b000;  // add, sub, addi
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;  // srl, sra
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;

  // alu operation codes, picked in decode
  localparam logic [alu_op_w-1:0] alu_add = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or  = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor = 4'd4;
  localparam logic [alu_op_w-1:0] alu_slt = 4'd5;
  localparam logic [alu_op_w-1:0] alu_sll = 4'd6;
  localparam logic [alu_op_w-1:0] alu_srl = 4'd7;
  localparam logic [alu_op_w-1:0] alu_sra = 4'd8;

  // ecall halts when a7 holds this
  localparam logic [xlen-1:0]       halt_code     = 32'd10;
  localparam logic [reg_addr_w-1:0] ecall_arg_reg = 5'd17;

  // one instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;   // imm[11:5] for stores, branch bits otherwise
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;   // imm[4:0] for stores
      logic [6:0] opcode;
    } s;
  } inst_t;

endpackage
